// ==== Makefile ====
VERILATOR   ?= verilator
TOP         ?= mmcm_cfg_tb
FILELIST    ?= files.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --binary --timing --assert -Wno-fatal
RUN_ARGS    ?= +verilator+error+limit+10
PASS_STRING ?= RESULT: PASS

SRCS := $(shell grep -v '^+' $(FILELIST)) common/mmcm_cfg_settings.svh
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_STRING)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/drp_pkg.sv ====
`default_nettype none

`include "mmcm_cfg_settings.svh"

package drp_pkg;

  // DRP request toward the clock manager
  typedef struct packed {
    logic [`DRP_ADDR_W-1:0] addr; // Word address
    logic                   den;  // Access enable, one cycle
    logic                   dwe;  // Write enable, only with den
    logic [`DRP_DATA_W-1:0] din;  // Write word
  } drp_req_t;

  // Output-0 divider configuration
  typedef struct packed {
    logic [5:0] high;   // High time in VCO cycles
    logic [5:0] low;    // Low time in VCO cycles
    logic [6:0] divide; // high + low
  } mmcm_clkout_t;

endpackage

`default_nettype wire

// ==== common/mmcm_cfg_settings.svh ====
`ifndef MMCM_CFG_SETTINGS_SVH
`define MMCM_CFG_SETTINGS_SVH

// Register bus
`define REG_BYTECNT_SIZE 7  // Byte counter width
`define REG_DRP_ADDR     0  // DRP address register, bit 7 selects write
`define REG_DRP_DATA     1  // DRP data register, two bytes

// DRP port
`define DRP_ADDR_W       7  // 128 configuration words
`define DRP_DATA_W       16 // Word width

// Word carrying output-0 high time [11:6] and low time [5:0]
`define DRP_CLKOUT0_REG  8

`endif

// ==== common/usb_reg_pkg.sv ====
`default_nettype none

`include "mmcm_cfg_settings.svh"

package usb_reg_pkg;

  // Top bit of header byte
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cmd_op_e;

  typedef enum logic [1:0] {
    IDLE,   // Waiting for header
    LENGTH, // Waiting for length byte
    WDATA,  // Forwarding write bytes
    RBURST  // Generating read strobes
  } dec_state_e;

  // Byte from the USB side
  typedef struct packed {
    logic       valid; // One-cycle byte strobe
    logic [7:0] data;
  } usb_byte_t;

  // One register access
  typedef struct packed {
    logic                          read;    // Read strobe
    logic                          write;   // Write strobe
    logic [7:0]                    addr;    // Register address
    logic [`REG_BYTECNT_SIZE-1:0]  bytecnt; // Byte index within access
    logic [7:0]                    datai;   // Write data
  } reg_bus_t;

  // Byte back to the host
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } usb_rsp_t;

endpackage

`default_nettype wire

// ==== drp/mmcm_drp_space.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mmcm_cfg_settings.svh"

module mmcm_drp_space
  import drp_pkg::*;
(
  input  wire logic                   clk_usb,
  input  wire logic                   reset_i,
  input  drp_req_t                    drp_req,  // Request from bridge
  output logic [`DRP_DATA_W-1:0]      drp_dout, // Combinational read
  output mmcm_clkout_t                clkout0   // Derived output-0 setting
);

  localparam int DEPTH = 1 << `DRP_ADDR_W;

  logic [`DRP_DATA_W-1:0] cfg_mem [DEPTH]; // Configuration words
  logic [`DRP_DATA_W-1:0] cfg_word;        // Output-0 word

  // No ready, data valid in the same cycle
  assign drp_dout = cfg_mem[drp_req.addr];
  assign cfg_word = cfg_mem[`DRP_CLKOUT0_REG];

  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        cfg_mem[i] <= '0; // Power-on configuration
      end
    end else if (drp_req.den && drp_req.dwe) begin
      cfg_mem[drp_req.addr] <= drp_req.din;
    end
  end

  // Divider fields, one cycle behind the word
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      clkout0 <= '0;
    end else begin
      clkout0.high   <= cfg_word[11:6];
      clkout0.low    <= cfg_word[5:0];
      clkout0.divide <= {1'b0, cfg_word[11:6]} + {1'b0, cfg_word[5:0]}; // Total period
    end
  end

endmodule

`default_nettype wire

// ==== drp/reg_mmcm_drp.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mmcm_cfg_settings.svh"

module reg_mmcm_drp
  import usb_reg_pkg::*;
  import drp_pkg::*;
(
  input  wire logic                   clk_usb,
  input  wire logic                   reset_i,
  input  reg_bus_t                    reg_bus,   // Access from decoder
  output logic [7:0]                  reg_datao, // Read byte, one cycle after strobe
  output drp_req_t                    drp_req,   // Toward DRP space
  input  wire logic [`DRP_DATA_W-1:0] drp_dout   // Word at current address
);

  // Writes load din byte by byte, then address with bit 7 set
  // Reads load address with bit 7 clear, then fetch from data register

  logic hi_byte; // Upper byte selected
  assign hi_byte = reg_bus.bytecnt[0];

  // Read path
  always_ff @(posedge clk_usb) begin
    if (reg_bus.read) begin
      case (reg_bus.addr)
        `REG_DRP_ADDR: reg_datao <= {1'b0, drp_req.addr};             // Bit 7 always clear
        `REG_DRP_DATA: reg_datao <= hi_byte ? drp_dout[15:8] : drp_dout[7:0];
        default:       reg_datao <= 8'h00;                             // Unmapped
      endcase
    end else begin
      reg_datao <= 8'h00; // Idle bus reads as zero
    end
  end

  // DRP strobes, one-cycle pulses
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      drp_req.den <= 1'b0;
      drp_req.dwe <= 1'b0;
    end else begin
      drp_req.den <= 1'b0;
      drp_req.dwe <= 1'b0;
      if (reg_bus.write && reg_bus.addr == `REG_DRP_ADDR) begin
        drp_req.den <= 1'b1;
        drp_req.dwe <= reg_bus.datai[7]; // Set means DRP write
      end
    end
  end

  // Address and write word, no reset
  always_ff @(posedge clk_usb) begin
    if (reg_bus.write) begin
      if (reg_bus.addr == `REG_DRP_ADDR)
        drp_req.addr <= reg_bus.datai[`DRP_ADDR_W-1:0];
      else if (reg_bus.addr == `REG_DRP_DATA) begin
        if (hi_byte)
          drp_req.din[15:8] <= reg_bus.datai;
        else
          drp_req.din[7:0] <= reg_bus.datai; // Low byte first
      end
    end
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+common
common/usb_reg_pkg.sv
common/drp_pkg.sv
logic/usb_cmd_decode.sv
drp/reg_mmcm_drp.sv
drp/mmcm_drp_space.sv
logic/usb_rsp_collect.sv
logic/mmcm_cfg_top.sv
verification/mmcm_cfg_clkgen.sv
verification/mmcm_cfg_assert.sv
verification/mmcm_cfg_tb.sv

// ==== logic/mmcm_cfg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mmcm_cfg_settings.svh"

module mmcm_cfg_top
  import usb_reg_pkg::*;
  import drp_pkg::*;
(
  input  wire logic clk_usb,
  input  wire logic reset_i,
  input  usb_byte_t host_in, // Host command bytes
  output logic      busy,    // Decoder busy
  output usb_rsp_t  rsp,     // Read bytes to host
  output mmcm_clkout_t clkout0
);

  reg_bus_t               reg_bus;   // Decoder to bridge
  logic [7:0]             reg_datao; // Bridge read byte
  drp_req_t               drp_req;   // Bridge to DRP space
  logic [`DRP_DATA_W-1:0] drp_dout;  // DRP read word

  usb_cmd_decode usb_cmd_decode_inst (
    .clk_usb (clk_usb),
    .reset_i (reset_i),
    .host_in (host_in),
    .reg_bus (reg_bus),
    .busy    (busy)
  );

  reg_mmcm_drp reg_mmcm_drp_inst (
    .clk_usb   (clk_usb),
    .reset_i   (reset_i),
    .reg_bus   (reg_bus),
    .reg_datao (reg_datao),
    .drp_req   (drp_req),
    .drp_dout  (drp_dout)
  );

  mmcm_drp_space mmcm_drp_space_inst (
    .clk_usb  (clk_usb),
    .reset_i  (reset_i),
    .drp_req  (drp_req),
    .drp_dout (drp_dout),
    .clkout0  (clkout0)
  );

  usb_rsp_collect usb_rsp_collect_inst (
    .clk_usb   (clk_usb),
    .reset_i   (reset_i),
    .rd_strobe (reg_bus.read), // Delayed inside to match bridge
    .reg_datao (reg_datao),
    .rsp       (rsp)
  );

endmodule

`default_nettype wire

// ==== logic/usb_cmd_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mmcm_cfg_settings.svh"

module usb_cmd_decode
  import usb_reg_pkg::*;
(
  input  wire logic      clk_usb,
  input  wire logic      reset_i,
  input  usb_byte_t      host_in,  // Byte stream from host
  output reg_bus_t       reg_bus,  // Registered strobes to the bridge
  output logic           busy      // Command in progress
);

  localparam int BCW = `REG_BYTECNT_SIZE;

  dec_state_e     state;
  cmd_op_e        op_q;     // Opcode latched from header
  logic [BCW-1:0] remain;   // Bytes or strobes still due
  logic [BCW-1:0] byte_idx; // Next byte count to issue

  always_ff @(posedge clk_usb) begin
    // Strobes last one cycle
    reg_bus.read  <= 1'b0;
    reg_bus.write <= 1'b0;
    if (reset_i) begin
      state         <= IDLE;
      busy          <= 1'b0;
      op_q          <= OP_READ;
      remain        <= '0;
      byte_idx      <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (host_in.valid) begin
            op_q         <= cmd_op_e'(host_in.data[7]);
            reg_bus.addr <= {1'b0, host_in.data[6:0]}; // Held for whole command
            busy         <= 1'b1;
            state        <= LENGTH;
          end
        end
        LENGTH: begin
          if (host_in.valid) begin
            if (host_in.data[BCW-1:0] == '0) begin
              // Empty command, nothing to do
              state <= IDLE;
              busy  <= 1'b0;
            end else if (op_q == OP_READ) begin
              reg_bus.read    <= 1'b1;                          // First read now
              reg_bus.bytecnt <= '0;
              byte_idx        <= BCW'(1);
              remain          <= host_in.data[BCW-1:0] - BCW'(1);
              state           <= RBURST;
            end else begin
              byte_idx <= '0;
              remain   <= host_in.data[BCW-1:0];
              state    <= WDATA;
            end
          end
        end
        WDATA: begin
          if (host_in.valid) begin
            reg_bus.write   <= 1'b1;
            reg_bus.datai   <= host_in.data;
            reg_bus.bytecnt <= byte_idx;
            byte_idx        <= byte_idx + BCW'(1);
            remain          <= remain - BCW'(1);
            if (remain == BCW'(1)) begin // Last byte
              state <= IDLE;
              busy  <= 1'b0;
            end
          end
        end
        RBURST: begin
          // Host bytes ignored here
          if (remain == '0) begin
            state <= IDLE;
            busy  <= 1'b0;
          end else begin
            reg_bus.read    <= 1'b1;
            reg_bus.bytecnt <= byte_idx;
            byte_idx        <= byte_idx + BCW'(1);
            remain          <= remain - BCW'(1);
          end
        end
        default: begin
          state <= IDLE;
          busy  <= 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/usb_rsp_collect.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_rsp_collect
  import usb_reg_pkg::*;
(
  input  wire logic       clk_usb,
  input  wire logic       reset_i,
  input  wire logic       rd_strobe, // Read strobe from decoder
  input  wire logic [7:0] reg_datao, // Bridge read byte
  output usb_rsp_t        rsp        // Byte stream to host
);

  logic rd_q; // Strobe aligned with bridge data

  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      rd_q      <= 1'b0;
      rsp.valid <= 1'b0;
    end else begin
      rd_q      <= rd_strobe;
      rsp.valid <= rd_q; // Two cycles after strobe
    end
  end

  // Payload follows the strobe pipeline, order kept
  always_ff @(posedge clk_usb) begin
    rsp.data <= reg_datao;
  end

endmodule

`default_nettype wire

// ==== verification/mmcm_cfg_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmcm_cfg_assert (
  input wire logic clk_usb,
  input wire logic reset_i,
  input wire logic den,       // DRP enable
  input wire logic dwe,       // DRP write enable
  input wire logic rd_strobe, // Decoder read strobe
  input wire logic rsp_valid  // Response strobe to host
);

  int unsigned fail_count = 0; // Failed assertions, polled by the testbench

  // DRP access lasts a single cycle
  den_pulse: assert property (@(posedge clk_usb) disable iff (reset_i) den |=> !den)
    else begin
      fail_count = fail_count + 1;
      $error("den held high for more than one cycle");
    end

  dwe_with_den: assert property (@(posedge clk_usb) disable iff (reset_i) dwe |-> den)
    else begin
      fail_count = fail_count + 1;
      $error("dwe high without den");
    end

  // Every read strobe gives one response byte two cycles later, and no other
  rsp_after_read: assert property (@(posedge clk_usb) disable iff (reset_i)
                                   rsp_valid == $past(rd_strobe, 2))
    else begin
      fail_count = fail_count + 1;
      $error("rsp valid not two cycles after read strobe");
    end

endmodule

bind mmcm_cfg_top mmcm_cfg_assert mmcm_cfg_assert_inst (
  .clk_usb   (clk_usb),
  .reset_i   (reset_i),
  .den       (drp_req.den),
  .dwe       (drp_req.dwe),
  .rd_strobe (reg_bus.read),
  .rsp_valid (rsp.valid)
);

`default_nettype wire

// ==== verification/mmcm_cfg_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmcm_cfg_clkgen #(
  parameter int PERIOD_NS    = 20, // USB-side clock period
  parameter int RESET_CYCLES = 3   // Rising edges with reset held
) (
  output logic clk_usb,
  output logic reset_i
);

  initial clk_usb = 1'b0;
  always #(PERIOD_NS / 2) clk_usb = ~clk_usb;

  initial begin
    reset_i = 1'b1; // High from time zero
    repeat (RESET_CYCLES) @(posedge clk_usb);
    reset_i <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== verification/mmcm_cfg_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mmcm_cfg_settings.svh"

module mmcm_cfg_tb
  import usb_reg_pkg::*;
  import drp_pkg::*;
();

  localparam int PERIOD_NS   = 20;
  localparam int NUM_ROUNDS  = 12;                  // Random DRP rounds
  localparam int NUM_CMDS    = NUM_ROUNDS * 8 + 8;  // Host commands over the run
  localparam int CMD_CYCLES  = 16;                  // Longest command plus drain
  localparam int WATCHDOG_NS = (NUM_CMDS * CMD_CYCLES + 40) * PERIOD_NS;

  logic         clk_usb;
  logic         reset_i;
  usb_byte_t    host_in;
  logic         busy;
  usb_rsp_t     rsp;
  mmcm_clkout_t clkout0;

  logic [15:0] model [128];        // Expected DRP words
  logic [15:0] din_model;          // Expected bridge write word
  logic [6:0]  addr_model;         // Expected DRP address
  logic [7:0]  rsp_q [$];          // Response bytes seen
  logic [6:0]  used_q [$];         // DRP addresses written so far
  logic [31:0] lfsr_state = 32'hde3d;

  mmcm_cfg_clkgen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(3)) mmcm_cfg_clkgen_inst (
    .clk_usb (clk_usb),
    .reset_i (reset_i)
  );

  mmcm_cfg_top mmcm_cfg_top_inst (
    .clk_usb (clk_usb),
    .reset_i (reset_i),
    .host_in (host_in),
    .busy    (busy),
    .rsp     (rsp),
    .clkout0 (clkout0)
  );

  // Sample mid-cycle, away from the clock edge
  always @(negedge clk_usb) begin
    if (rsp.valid === 1'b1) rsp_q.push_back(rsp.data);
    if (mmcm_cfg_top_inst.mmcm_cfg_assert_inst.fail_count != 0) begin
      $display("Bound assertion failed, see message above");
      $display("RESULT: FAIL");
      $fatal(1, "Assertion failure");
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, the run is stuck");
    $display("RESULT: FAIL");
    $fatal(1, "Timeout");
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r          = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERROR: time %0t signal %s expected %0h actual %0h", $time, name, exp, act);
      $display("RESULT: FAIL");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout: %s", what);
    $display("RESULT: FAIL");
    $fatal(1, "Handshake timeout");
  endtask

  task automatic send_byte(input logic [7:0] b);
    @(posedge clk_usb);
    host_in <= '{valid: 1'b1, data: b};
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    @(posedge clk_usb);
    host_in <= '0; // Bus quiet after last byte
    @(negedge clk_usb);
    while (busy !== 1'b0) begin
      n++;
      if (n > CMD_CYCLES) timeout_fail("busy stayed high");
      @(negedge clk_usb);
    end
  endtask

  // Header, length, then payload low byte first
  task automatic write_cmd(input logic [6:0] addr, input int n, input logic [15:0] payload);
    send_byte({OP_WRITE, addr});
    send_byte(8'(n));
    for (int i = 0; i < n; i++) begin
      send_byte(payload[8*i +: 8]);
    end
    wait_idle();
  endtask

  task automatic read_cmd(input logic [6:0] addr, input int n);
    int waited;
    waited = 0;
    rsp_q.delete();
    send_byte({OP_READ, addr});
    send_byte(8'(n));
    @(posedge clk_usb);
    host_in <= '0; // Length byte lasts one cycle
    while (rsp_q.size() < n) begin
      @(negedge clk_usb);
      waited++;
      if (waited > n + 8) timeout_fail("response bytes missing");
    end
    wait_idle();
  endtask

  task automatic expect_rsp(input logic [7:0] exp);
    check_value("rsp.data", 32'(exp), 32'(rsp_q.pop_front()));
  endtask

  task automatic write_data(input logic [15:0] w);
    write_cmd(7'(`REG_DRP_DATA), 2, w);
    din_model = w;
  endtask

  // Load din, then DRP write at a
  task automatic drp_write(input logic [6:0] a, input logic [15:0] w);
    write_data(w);
    write_cmd(7'(`REG_DRP_ADDR), 1, {9'h001, a});
    model[a]   = din_model;
    addr_model = a;
  endtask

  // DRP read access at a, then fetch both bytes
  task automatic drp_read_check(input logic [6:0] a);
    write_cmd(7'(`REG_DRP_ADDR), 1, {9'h000, a});
    addr_model = a;
    read_cmd(7'(`REG_DRP_DATA), 2);
    expect_rsp(model[a][7:0]);
    expect_rsp(model[a][15:8]);
  endtask

  task automatic check_clkout();
    mmcm_clkout_t exp;
    exp.high   = model[`DRP_CLKOUT0_REG][11:6];
    exp.low    = model[`DRP_CLKOUT0_REG][5:0];
    exp.divide = 7'(exp.high) + 7'(exp.low);
    check_value("clkout0", 32'(exp), 32'(clkout0));
  endtask

  initial begin
    logic [6:0]  a;
    int          n;
    host_in   = '0;
    din_model = '0;
    for (int i = 0; i < 128; i++) begin
      model[i] = '0; // DRP space clears on reset
    end
    @(negedge clk_usb);
    while (reset_i) @(negedge clk_usb);
    check_value("busy", 32'h0, 32'(busy));
    check_value("rsp.valid", 32'h0, 32'(rsp.valid));
    check_value("clkout0", 32'h0, 32'(clkout0));
    for (int r = 0; r < NUM_ROUNDS; r++) begin
      a = 7'(rand_bits(7));
      drp_write(a, 16'(rand_bits(16)));
      drp_read_check(a);
      read_cmd(7'(`REG_DRP_ADDR), 1); // Address readback
      expect_rsp({1'b0, addr_model});
      used_q.push_back(a);
      a = used_q[rand_bits(5) % used_q.size()];
      write_data(16'(rand_bits(16))); // New din, no DRP write
      drp_read_check(a);              // Word must be unchanged
      check_clkout();
    end
    drp_write(7'(`DRP_CLKOUT0_REG), {4'h0, 6'(rand_bits(6)), 6'(rand_bits(6))});
    drp_read_check(7'(`DRP_CLKOUT0_REG));
    check_clkout();
    for (int r = 0; r < 4; r++) begin
      a = 7'(2 + rand_bits(7) % 126); // Unmapped register
      n = 1 + int'(rand_bits(2));
      read_cmd(a, n);
      for (int i = 0; i < n; i++) begin
        expect_rsp(8'h00);
      end
    end
    if (mmcm_cfg_top_inst.mmcm_cfg_assert_inst.fail_count == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("RESULT: FAIL");
      $fatal(1, "Assertion failures seen");
    end
  end

endmodule

`default_nettype wire
